//--- design/vuop_pkg.sv
// shared vector micro-op types and encodings, imported by every block of the expansion stage.
`default_nettype none

package vuop_pkg;

  // major opcodes of the vector extension.
  localparam logic [6:0] OPC_OPV    = 7'b1010111;
  localparam logic [6:0] OPC_VLOAD  = 7'b0000111; // shared with scalar LOAD-FP.
  localparam logic [6:0] OPC_VSTORE = 7'b0100111; // shared with scalar STORE-FP.

  // funct3 of the vector-vector forms, the only ones with a vs1 register.
  localparam logic [2:0] F3_OPIVV = 3'd0;
  localparam logic [2:0] F3_OPFVV = 3'd1;
  localparam logic [2:0] F3_OPMVV = 3'd2;

  // mop codes for indexed addressing.
  localparam logic [1:0] MOP_IDX_UNORD = 2'b01;
  localparam logic [1:0] MOP_IDX_ORD   = 2'b11;

  // OP-V arithmetic layout.
  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;
    logic [2:0] funct3;
    logic [4:0] vd;
    logic [6:0] opcode;
  } varith_t;

  // vector load/store layout.
  typedef struct packed {
    logic [2:0] nf;
    logic       mew;
    logic [1:0] mop;
    logic       vm;
    logic [4:0] vs2;    // rs2 for strided, vs2 for indexed.
    logic [4:0] rs1;    // base address.
    logic [2:0] width;
    logic [4:0] vd;     // vs3 for stores.
    logic [6:0] opcode;
  } vmem_t;

  // one instruction word, two decodings.
  typedef union packed {
    varith_t arith;
    vmem_t   mem;
  } vinstr_u;

  // request accepted on the strobe.
  typedef struct packed {
    vinstr_u    instr;
    logic [3:0] lmul;
  } uop_req_t;

  // which register fields step with the micro-op index.
  typedef struct packed {
    logic adv_vd;
    logic adv_vs1;
    logic adv_vs2;
  } bump_t;

  // effective group size, zero taken as one and capped by the buffer depth.
  function automatic logic [3:0] clamp_lmul(input logic [3:0] lmul,
                                            input int unsigned max_lmul);
    logic [3:0] n;
    n = (lmul == 4'd0) ? 4'd1 : lmul;
    if (n > max_lmul) begin
      n = 4'(max_lmul);
    end
    return n;
  endfunction

endpackage

`default_nettype wire

//--- design/vinstr_classifier.sv
// combinational decode of a vector instruction into the register fields that step per micro-op.
`timescale 1ns/1ns
`default_nettype none

module vinstr_classifier (
  input  vuop_pkg::vinstr_u instr,
  output vuop_pkg::bump_t   bump
);

  import vuop_pkg::*;

  logic is_opv;    // arithmetic / config space.
  logic is_load;
  logic is_store;
  logic is_mem;
  logic is_vv;     // vector-vector operand form.
  logic is_index;  // indexed addressing.

  // opcode is in the same bits in both views.
  assign is_opv   = (instr.arith.opcode == OPC_OPV);
  assign is_load  = (instr.mem.opcode == OPC_VLOAD);
  assign is_store = (instr.mem.opcode == OPC_VSTORE);
  assign is_mem   = is_load | is_store;

  // only the three vector-vector categories carry a vs1 register.
  always_comb begin
    case (instr.arith.funct3)
      F3_OPIVV, F3_OPFVV, F3_OPMVV: is_vv = 1'b1;
      default:                      is_vv = 1'b0;
    endcase
  end

  // unit-stride and strided forms use rs2 or lumop there, not a vector.
  always_comb begin
    case (instr.mem.mop)
      MOP_IDX_UNORD, MOP_IDX_ORD: is_index = 1'b1;
      default:                    is_index = 1'b0;
    endcase
  end

  // destination group, or store data group, always steps.
  assign bump.adv_vd  = is_opv | is_mem;

  // scalar and immediate forms keep rs1/imm as is.
  assign bump.adv_vs1 = is_opv & is_vv;

  // index vector group for indexed memory ops.
  assign bump.adv_vs2 = is_opv | (is_mem & is_index);

endmodule

`default_nettype wire

//--- design/uop_expand_buffer.sv
// builds the register-stepped copies of an instruction and shifts them out one per cycle.
`timescale 1ns/1ns
`default_nettype none

module uop_expand_buffer #(
  parameter int unsigned MAX_LMUL = 8
) (
  input  logic               CLK,
  input  logic               nRST,
  input  vuop_pkg::uop_req_t req,
  input  vuop_pkg::bump_t    bump,
  input  logic               load,
  input  logic               shift,
  input  logic               clear,
  output vuop_pkg::vinstr_u  uop
);

  import vuop_pkg::*;

  logic [3:0] n_eff;                    // copies actually stored.
  vinstr_u [MAX_LMUL-1:0] next_buf;     // candidate contents on load.
  vinstr_u [MAX_LMUL-1:0] buf_q;        // word 0 is the current micro-op.

  assign n_eff = clamp_lmul(req.lmul, MAX_LMUL);

  // copy k advances each flagged field by k, wrapping within 5 bits.
  always_comb begin
    vinstr_u cp;
    cp = req.instr;
    for (int k = 0; k < MAX_LMUL; k++) begin
      cp = req.instr;
      if (bump.adv_vd) begin
        cp.arith.vd = req.instr.arith.vd + 5'(k);
      end
      if (bump.adv_vs1) begin
        cp.arith.vs1 = req.instr.arith.vs1 + 5'(k);
      end
      if (bump.adv_vs2) begin
        cp.arith.vs2 = req.instr.arith.vs2 + 5'(k);
      end
      next_buf[k] = (k < n_eff) ? cp : '0; // unused slots stay zero.
    end
  end

  // clear wins over everything, then load, then shift.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      buf_q <= '0;
    end else if (clear) begin
      buf_q <= '0;
    end else if (load) begin
      buf_q <= next_buf;
    end else if (shift) begin
      for (int k = 0; k < MAX_LMUL - 1; k++) begin
        buf_q[k] <= buf_q[k+1];
      end
      buf_q[MAX_LMUL-1] <= '0;          // zero fills from the top.
    end
  end

  assign uop = buf_q[0];

  // the controller loads only from idle and shifts only while issuing.
  a_no_load_during_shift: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(load && shift)
  ) else $error("buffer load and shift asserted together");

endmodule

`default_nettype wire

//--- design/uop_count.sv
// counts the micro-ops of the current group still to issue and flags the final one.
`timescale 1ns/1ns
`default_nettype none

module uop_count #(
  parameter int unsigned MAX_LMUL = 8
) (
  input  logic       CLK,
  input  logic       nRST,
  input  logic [3:0] lmul,
  input  logic       load,
  input  logic       shift,
  input  logic       clear,
  output logic       last
);

  import vuop_pkg::*;

  localparam int unsigned CW = $clog2(MAX_LMUL + 1);

  logic [CW-1:0] cnt_q; // micro-ops left, including the one on the output.

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt_q <= '0;
    end else if (clear) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= CW'(clamp_lmul(lmul, MAX_LMUL));
    end else if (shift) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign last = (cnt_q == CW'(1));

  // the controller must leave issue at the edge where last is seen.
  a_no_shift_when_empty: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(shift && (cnt_q == '0))
  ) else $error("micro-op counter shifted while empty");

endmodule

`default_nettype wire

//--- design/uop_seq_fsm.sv
// two-state controller that loads, steps and flushes the micro-op buffer and counter.
`timescale 1ns/1ns
`default_nettype none

module uop_seq_fsm (
  input  logic CLK,
  input  logic nRST,
  input  logic req_valid,
  input  logic flush,
  input  logic last,
  output logic load,
  output logic shift,
  output logic clear,
  output logic uop_valid,
  output logic busy,
  output logic dropped
);

  localparam logic IDLE  = 1'b0;
  localparam logic ISSUE = 1'b1;

  logic state_q;
  logic state_d;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    load    = 1'b0;
    case (state_q)
      IDLE: begin
        if (req_valid && !flush) begin
          load    = 1'b1;
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        if (last) begin
          state_d = IDLE;  // final micro-op leaves this cycle.
        end
      end
      default: state_d = IDLE;
    endcase
    if (flush) begin
      state_d = IDLE;
    end
  end

  assign busy      = (state_q == ISSUE);
  assign uop_valid = busy;             // one micro-op on every issue cycle.
  assign shift     = busy & ~flush;
  assign clear     = flush;
  assign dropped   = req_valid & busy; // no queueing while a group runs.

  // the counter flags a final micro-op only while a group is issuing.
  a_last_only_in_issue: assert property (
    @(posedge CLK) disable iff (!nRST)
    last |-> busy
  ) else $error("counter flagged last while the controller was idle");

endmodule

`default_nettype wire

//--- design/vuop_expander.sv
// top of the vector micro-op expansion stage; one instruction in, lmul micro-ops out.
`timescale 1ns/1ns
`default_nettype none

module vuop_expander #(
  parameter int unsigned MAX_LMUL = 8
) (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               req_valid,
  input  vuop_pkg::uop_req_t req,
  input  logic               flush,
  output logic               uop_valid,
  output vuop_pkg::vinstr_u  uop,
  output logic               busy,
  output logic               dropped
);

  import vuop_pkg::*;

  bump_t bump;   // field step flags for the incoming word.
  logic  load;
  logic  shift;
  logic  clear;
  logic  last;

  vinstr_classifier vinstr_classifier_i (
    .instr (req.instr),
    .bump  (bump)
  );

  uop_expand_buffer #(
    .MAX_LMUL (MAX_LMUL)
  ) uop_expand_buffer_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .req   (req),
    .bump  (bump),
    .load  (load),
    .shift (shift),
    .clear (clear),
    .uop   (uop)
  );

  uop_count #(
    .MAX_LMUL (MAX_LMUL)
  ) uop_count_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .lmul  (req.lmul),
    .load  (load),
    .shift (shift),
    .clear (clear),
    .last  (last)
  );

  uop_seq_fsm uop_seq_fsm_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_valid (req_valid),
    .flush     (flush),
    .last      (last),
    .load      (load),
    .shift     (shift),
    .clear     (clear),
    .uop_valid (uop_valid),
    .busy      (busy),
    .dropped   (dropped)
  );

endmodule

`default_nettype wire

//--- sim/vuop_expander_tb.sv
// testbench for the vector micro-op expander; runs the cases in the vectors file plus random OP-V words.
`timescale 1ns/1ns
`default_nettype none

module vuop_expander_tb;

  import vuop_pkg::*;

  localparam int unsigned DUT_MAX_LMUL = 8;
  localparam int MAX_TESTS  = 64;
  localparam int RAND_TESTS = 6;
  localparam int IDLE_LIMIT = 40;                // cycles allowed for busy to fall.
  localparam logic [31:0] ALT_MASK = 32'h0000_0f80; // flips vd to make a distinct word.

  // major opcodes as the ISA encodes them, for the reference model.
  localparam logic [6:0] ISA_OPV   = 7'h57;
  localparam logic [6:0] ISA_LOAD  = 7'h07;
  localparam logic [6:0] ISA_STORE = 7'h27;

  logic        CLK;
  logic        nRST;
  logic        req_valid;
  uop_req_t    req;
  logic        flush;
  logic        uop_valid;
  logic [31:0] uop;
  logic        busy;
  logic        dropped;

  logic [31:0] vec_mem [0:4*MAX_TESTS-1]; // four words per test.
  int seed;
  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;
  bit timed_out;

  vuop_expander #(
    .MAX_LMUL (DUT_MAX_LMUL)
  ) vuop_expander_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .req_valid (req_valid),
    .req       (req),
    .flush     (flush),
    .uop_valid (uop_valid),
    .uop       (uop),
    .busy      (busy),
    .dropped   (dropped)
  );

  always #50 CLK = ~CLK;

  // number of micro-ops a group really issues.
  function automatic int group_len(input logic [3:0] lmul);
    if (lmul == 4'd0) begin
      return 1;
    end
    if (lmul > 4'(DUT_MAX_LMUL)) begin
      return DUT_MAX_LMUL;
    end
    return int'(lmul);
  endfunction

  // micro-op k of a word: vd for all vector ops, vs1 for vv forms, vs2 for OP-V and indexed.
  task automatic reference_uop(input logic [31:0] instr, input int k, output logic [31:0] exp);
    logic is_opv;
    logic is_mem;
    logic is_index;
    is_opv   = (instr[6:0] == ISA_OPV);
    is_mem   = (instr[6:0] == ISA_LOAD) || (instr[6:0] == ISA_STORE);
    is_index = (instr[27:26] == 2'b01) || (instr[27:26] == 2'b11);
    exp = instr;
    if (is_opv || is_mem) begin
      exp[11:7] = instr[11:7] + 5'(k);
    end
    if (is_opv && (instr[14:12] <= 3'd2)) begin
      exp[19:15] = instr[19:15] + 5'(k); // OPIVV, OPFVV, OPMVV.
    end
    if (is_opv || (is_mem && is_index)) begin
      exp[24:20] = instr[24:20] + 5'(k);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
      test_errors++;
    end
  endtask

  task automatic check_idle(input bit check_uop);
    check_value("uop_valid", uop_valid, 1'b0);
    check_value("busy", busy, 1'b0);
    check_value("dropped", dropped, 1'b0);
    if (check_uop) begin
      check_value("uop", uop, 32'h0); // empty buffer after reset or flush.
    end
  endtask

  task automatic wait_idle(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < IDLE_LIMIT && !ok; n++) begin
      @(negedge CLK);
      ok = !busy;
    end
    if (!ok) begin
      $display("timeout: busy stayed high for %0d cycles", IDLE_LIMIT);
    end
  endtask

  // entered just after the load edge; returns just after the edge that ends the group.
  task automatic check_group(input logic [31:0] instr, input logic [3:0] lmul,
                             input int flush_at, input bit collide);
    logic [31:0] exp;
    int n;
    bit flushed;
    n = group_len(lmul);
    flushed = 1'b0;
    for (int k = 0; k < n && !flushed; k++) begin
      req_valid <= collide && (k == 0);     // strobe while busy is dropped.
      if (collide && (k == 0)) begin
        req <= {instr ^ ALT_MASK, 4'd3};
      end
      flush <= (k + 1 == flush_at);
      reference_uop(instr, k, exp);
      @(negedge CLK);
      check_value("uop_valid", uop_valid, 1'b1);
      check_value("busy", busy, 1'b1);
      check_value("dropped", dropped, collide && (k == 0));
      check_value("uop", uop, exp);
      flushed = (k + 1 == flush_at);
      @(posedge CLK);
    end
  endtask

  task automatic run_test(input int num, input logic [31:0] instr, input logic [3:0] lmul,
                          input int flush_at, input bit collide);
    bit ok;
    test_errors = 0;
    wait_idle(ok);
    if (!ok) begin
      timed_out = 1'b1;
      return;
    end
    @(posedge CLK);
    req_valid <= 1'b1;
    req       <= {instr, lmul};
    @(posedge CLK);
    check_group(instr, lmul, flush_at, collide);
    if (collide) begin
      // follow-up request in the first non-busy cycle.
      req_valid <= 1'b1;
      req       <= {instr ^ ALT_MASK, 4'd2};
      flush     <= 1'b0;
      @(negedge CLK);
      check_idle(1'b0);
      @(posedge CLK);
      check_group(instr ^ ALT_MASK, 4'd2, 0, 1'b0);
    end
    req_valid <= 1'b0;
    flush     <= 1'b0;
    @(negedge CLK);
    check_idle(flush_at != 0);
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("test %0d: instr 0x%h lmul %0d ok", num, instr, lmul);
    end else begin
      tests_failed++;
      $display("test %0d: instr 0x%h lmul %0d failed, %0d errors", num, instr, lmul,
               test_errors);
    end
  endtask

  initial begin
    int i;
    logic [31:0] r_instr;
    logic [3:0]  r_lmul;
    CLK       = 1'b0;
    nRST      = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    flush     = 1'b0;
    seed         = 25;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    $readmemh("sim/uop_vectors.txt", vec_mem);
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;

    // outputs right after reset, before any request.
    test_errors = 0;
    @(negedge CLK);
    check_idle(1'b1);
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("test 0: reset state ok");
    end else begin
      tests_failed++;
      $display("test 0: reset state failed, %0d errors", test_errors);
    end

    i = 0;
    while (i < MAX_TESTS && !$isunknown(vec_mem[4*i]) && !timed_out) begin
      run_test(i + 1, vec_mem[4*i], vec_mem[4*i+1][3:0], int'(vec_mem[4*i+2]),
               vec_mem[4*i+3][0]);
      i++;
    end

    for (int r = 0; r < RAND_TESTS && !timed_out; r++) begin
      r_instr = $random(seed);
      r_instr[6:0] = ISA_OPV;                  // random fields, OP-V opcode.
      r_lmul = 4'(1 + ($unsigned($random(seed)) % 8));
      run_test(i + r + 1, r_instr, r_lmul, 0, 1'b0);
    end

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/uop_vectors.txt
// columns: instruction, lmul, flush cycle (1-based issue cycle, 0 for none), collision flag.
// all values in hex, one test per line.

// OP-V vector-vector forms, lmul 1 to 8.
02860257 8 0 0
03ee9e57 4 0 0
942fa0d7 2 0 0
0a5303d7 1 0 0
02860257 5 0 0
03ee9e57 7 0 0
942fa0d7 6 0 0
0a5303d7 3 0 0

// OP-V scalar and immediate forms.
02a1ca57 4 0 0
03f2bf57 4 0 0

// unit-stride and strided loads and stores.
02056407 8 0 0
0a72df07 4 0 0
02008127 2 0 0
08b4f827 8 0 0

// indexed loads and stores.
07c16207 8 0 0
0e618fa7 4 0 0
0e1fd007 3 0 0
05446627 2 0 0

// non-vector words repeat unchanged.
00510093 4 0 0
0002a303 8 0 0

// request while busy, then a request in the first idle cycle.
02860257 4 0 1
07c16207 1 0 1

// flush partway, on the first cycle and on the last cycle.
03ee9e57 8 3 0
0a72df07 6 1 0
02a1ca57 2 2 0
942fa0d7 5 0 0

//--- tb.f
design/vuop_pkg.sv
design/vinstr_classifier.sv
design/uop_expand_buffer.sv
design/uop_count.sv
design/uop_seq_fsm.sv
design/vuop_expander.sv
sim/vuop_expander_tb.sv

//--- Bender.yml
package:
  name: vuop_expander

sources:
  - design/vuop_pkg.sv
  - design/vinstr_classifier.sv
  - design/uop_expand_buffer.sv
  - design/uop_count.sv
  - design/uop_seq_fsm.sv
  - design/vuop_expander.sv
  - target: test
    files:
      - sim/vuop_expander_tb.sv
